// ==== cnn_pkg.sv ====
package cnn_pkg;

    // geometry of one tile and one kernel
    localparam int ch_num      = 4;
    localparam int tile_dim    = 4;
    localparam int kernel_dim  = 3;
    localparam int taps_per_ch = kernel_dim * kernel_dim;
    localparam int taps_total  = ch_num * taps_per_ch;

    // output block edge and size
    localparam int out_dim     = tile_dim - kernel_dim + 1;
    localparam int out_pos     = out_dim * out_dim;

    // data widths
    localparam int act_w       = 8;
    localparam int param_w     = 4;
    // 36 products of 8x4 bits plus the aligned bias stay well inside this
    localparam int acc_w       = 18;

    // fixed-point requantize constants
    localparam int frac_shift  = 7;
    localparam int round_const = 1 << (frac_shift - 1);
    localparam int act_max     = 127;

    // pixel (c, r, k) at byte c*16 + r*4 + k
    typedef logic [ch_num*tile_dim*tile_dim*act_w-1:0] tile_t;

    // one channel, tap ky*3 + kx at nibble ky*3 + kx
    typedef logic [taps_per_ch*param_w-1:0] weight_word_t;

    // all channels, entry c*9 + tap
    typedef logic [taps_total*param_w-1:0] weights_t;

    // activations for one output position, same order as weights_t
    typedef logic [taps_total*act_w-1:0] window_t;

    // position row*2 + col at byte p
    typedef logic [out_pos*act_w-1:0] out_block_t;

endpackage

// ==== param_loader.sv ====
`timescale 1ns/10ps

module param_loader #(
    parameter int CH_NUM = cnn_pkg::ch_num
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            param_req,
    input  logic                            param_is_bias,
    input  cnn_pkg::weight_word_t           param_data,
    output logic                            param_ack,
    output logic                            tile_ready,
    output cnn_pkg::weights_t               weights,
    output logic signed [cnn_pkg::param_w-1:0] bias
);

    import cnn_pkg::*;

    localparam int cnt_w = $clog2(CH_NUM + 1);

    // channel c lives at index c, newest word enters at the top
    weight_word_t [CH_NUM-1:0] wreg;

    logic [cnt_w-1:0] wcount;
    logic             bias_seen;
    logic             capture;

    // a new request is only taken while ack is low
    assign capture = rst_n && param_req && !param_ack;

    // four-phase responder plus load bookkeeping
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            param_ack <= 1'b0;
            wcount    <= '0;
            bias_seen <= 1'b0;
        end else begin
            if (capture) begin
                param_ack <= 1'b1;
                if (param_is_bias) begin
                    bias_seen <= 1'b1;
                end else if (wcount != cnt_w'(CH_NUM)) begin
                    wcount <= wcount + 1'b1;
                end
            end else if (!param_req && param_ack) begin
                param_ack <= 1'b0;
            end
        end
    end

    // weight shift register and bias
    always_ff @(posedge clk) begin
        if (capture) begin
            if (param_is_bias) begin
                bias <= param_data[param_w-1:0];
            end else begin
                // drop channel 0, move the rest down one slot
                wreg <= {param_data, wreg[CH_NUM-1:1]};
            end
        end
    end

    assign weights = wreg;

    // ready once a full set has arrived, later loads update in place
    assign tile_ready = (wcount == cnt_w'(CH_NUM)) && bias_seen;

    // ack only answers a request seen on the previous edge
    ack_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(param_ack) |-> $past(param_req)
    );

    // once loaded, the engine never drops back to not ready
    ready_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        tile_ready |=> tile_ready
    );

endmodule

// ==== window_gather.sv ====
`timescale 1ns/10ps

module window_gather (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tile_valid,
    input  logic             tile_ready,
    input  cnn_pkg::tile_t   tile_data,
    output logic             win_valid,
    output cnn_pkg::window_t windows [cnn_pkg::out_pos]
);

    import cnn_pkg::*;

    tile_t tile_q;
    logic  accept;

    // the one place a tile gets accepted
    assign accept = tile_valid && tile_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tile_q <= tile_data;
        end
    end

    // position (r, k) sees rows r..r+2 and cols k..k+2 of each channel
    always_comb begin
        int p;
        int c;
        int ky;
        int kx;
        int r;
        int k;
        int src;
        int dst;
        for (p = 0; p < out_pos; p++) begin
            r = p / out_dim;
            k = p % out_dim;
            for (c = 0; c < ch_num; c++) begin
                for (ky = 0; ky < kernel_dim; ky++) begin
                    for (kx = 0; kx < kernel_dim; kx++) begin
                        src = c * tile_dim * tile_dim + (r + ky) * tile_dim + (k + kx);
                        dst = c * taps_per_ch + ky * kernel_dim + kx;
                        windows[p][dst*act_w +: act_w] = tile_q[src*act_w +: act_w];
                    end
                end
            end
        end
    end

endmodule

// ==== mac_array.sv ====
`timescale 1ns/10ps

module mac_array #(
    parameter int CH_NUM = cnn_pkg::ch_num
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            win_valid,
    input  cnn_pkg::window_t                windows [cnn_pkg::out_pos],
    input  cnn_pkg::weights_t               weights,
    output logic                            sum_valid,
    output logic signed [cnn_pkg::acc_w-1:0] sums [cnn_pkg::out_pos]
);

    import cnn_pkg::*;

    // one kernel row per channel and ky
    localparam int rows   = CH_NUM * kernel_dim;
    // three 12-bit products need two more bits
    localparam int part_w = act_w + param_w + 2;

    logic signed [part_w-1:0] part_d [out_pos][rows];
    logic signed [part_w-1:0] part_q [out_pos][rows];
    logic signed [acc_w-1:0]  total_d [out_pos];
    logic                     v1;

    // stage 1 products, summed per kernel row
    always_comb begin
        int p;
        int row;
        int kx;
        int idx;
        logic signed [act_w-1:0]   a;
        logic signed [param_w-1:0] w;
        logic signed [part_w-1:0]  acc;
        for (p = 0; p < out_pos; p++) begin
            for (row = 0; row < rows; row++) begin
                acc = '0;
                for (kx = 0; kx < kernel_dim; kx++) begin
                    idx = row * kernel_dim + kx;
                    a   = windows[p][idx*act_w +: act_w];
                    w   = weights[idx*param_w +: param_w];
                    acc = acc + part_w'(a) * part_w'(w);
                end
                part_d[p][row] = acc;
            end
        end
    end

    // stage 2 adder tree over the row partials
    always_comb begin
        int p;
        int row;
        logic signed [acc_w-1:0] tot;
        for (p = 0; p < out_pos; p++) begin
            tot = '0;
            for (row = 0; row < rows; row++) begin
                tot = tot + acc_w'(part_q[p][row]);
            end
            total_d[p] = tot;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1        <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            v1        <= win_valid;
            sum_valid <= v1;
        end
    end

    always_ff @(posedge clk) begin
        part_q <= part_d;
        sums   <= total_d;
    end

endmodule

// ==== requantize.sv ====
`timescale 1ns/10ps

module requantize (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               sum_valid,
    input  logic signed [cnn_pkg::acc_w-1:0]   sums [cnn_pkg::out_pos],
    input  logic signed [cnn_pkg::param_w-1:0] bias,
    output logic                               out_valid,
    output cnn_pkg::out_block_t                out_block
);

    import cnn_pkg::*;

    logic signed [acc_w-1:0] bias_term;
    out_block_t              block_d;

    // bias lifted to the fraction point of the accumulator
    assign bias_term = acc_w'(bias) <<< frac_shift;

    always_comb begin
        int p;
        logic signed [acc_w-1:0] t;
        for (p = 0; p < out_pos; p++) begin
            t = sums[p] + bias_term + acc_w'(round_const);
            t = t >>> frac_shift;
            // relu, then saturate
            if (t < 0) begin
                block_d[p*act_w +: act_w] = '0;
            end else if (t > acc_w'(act_max)) begin
                block_d[p*act_w +: act_w] = act_w'(act_max);
            end else begin
                block_d[p*act_w +: act_w] = t[act_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_block <= block_d;
    end

    for (genvar p = 0; p < out_pos; p++) begin : g_range_chk
        out_in_range: assert property (
            @(posedge clk) disable iff (!rst_n)
            out_valid |-> (out_block[p*act_w +: act_w] <= act_w'(act_max))
        );
    end

endmodule

// ==== conv_engine_top.sv ====
`timescale 1ns/10ps

module conv_engine_top #(
    parameter int CH_NUM = cnn_pkg::ch_num
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // parameter load, four-phase req/ack
    input  logic                  param_req,
    input  logic                  param_is_bias,
    input  cnn_pkg::weight_word_t param_data,
    output logic                  param_ack,

    // tile stream
    input  logic                  tile_valid,
    input  cnn_pkg::tile_t        tile_data,
    output logic                  tile_ready,

    // one 2x2 block per tile, four cycles after accept
    output logic                  out_valid,
    output cnn_pkg::out_block_t   out_block
);

    import cnn_pkg::*;

    weights_t                weights;
    logic signed [param_w-1:0] bias;

    logic                    win_valid;
    window_t                 windows [out_pos];

    logic                    sum_valid;
    logic signed [acc_w-1:0] sums [out_pos];

    param_loader #(
        .CH_NUM(CH_NUM)
    ) i_param_loader (
        .clk          (clk),
        .rst_n        (rst_n),
        .param_req    (param_req),
        .param_is_bias(param_is_bias),
        .param_data   (param_data),
        .param_ack    (param_ack),
        .tile_ready   (tile_ready),
        .weights      (weights),
        .bias         (bias)
    );

    window_gather i_window_gather (
        .clk       (clk),
        .rst_n     (rst_n),
        .tile_valid(tile_valid),
        .tile_ready(tile_ready),
        .tile_data (tile_data),
        .win_valid (win_valid),
        .windows   (windows)
    );

    mac_array #(
        .CH_NUM(CH_NUM)
    ) i_mac_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .win_valid(win_valid),
        .windows  (windows),
        .weights  (weights),
        .sum_valid(sum_valid),
        .sums     (sums)
    );

    requantize i_requantize (
        .clk      (clk),
        .rst_n    (rst_n),
        .sum_valid(sum_valid),
        .sums     (sums),
        .bias     (bias),
        .out_valid(out_valid),
        .out_block(out_block)
    );

endmodule

// ==== tb_conv_model.svh ====
`ifndef TB_CONV_MODEL_SVH
`define TB_CONV_MODEL_SVH

// one xorshift32 step, a nonzero state never maps to zero
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// expected 2x2 block from plain signed arithmetic
function automatic out_block_t conv_expect(
    input tile_t                     tile,
    input weights_t                  w,
    input logic signed [param_w-1:0] b
);
    out_block_t                blk;
    int                        p;
    int                        c;
    int                        ky;
    int                        kx;
    int                        acc;
    int                        res;
    logic signed [act_w-1:0]   px;
    logic signed [param_w-1:0] wt;
    blk = '0;
    for (p = 0; p < out_pos; p++) begin
        acc = 0;
        for (c = 0; c < ch_num; c++) begin
            for (ky = 0; ky < 3; ky++) begin
                for (kx = 0; kx < 3; kx++) begin
                    // output row p/2, col p%2
                    px  = tile[(c*16 + (p/2 + ky)*4 + (p%2 + kx))*act_w +: act_w];
                    wt  = w[(c*9 + ky*3 + kx)*param_w +: param_w];
                    acc = acc + int'(px) * int'(wt);
                end
            end
        end
        res = (acc + int'(b) * 128 + 64) >>> 7;
        if (res < 0) begin
            res = 0;
        end else if (res > 127) begin
            res = 127;
        end
        blk[p*act_w +: act_w] = res[7:0];
    end
    return blk;
endfunction

`endif

// ==== tb_conv_engine.sv ====
`timescale 1ns/10ps

module tb_conv_engine;

    import cnn_pkg::*;

    localparam int max_cycles   = 2000;
    localparam int rand_tiles   = 40;
    localparam int reload_tiles = 10;
    localparam int exp_depth    = 64;

    logic         clk;
    logic         rst_n;
    logic         param_req;
    logic         param_is_bias;
    weight_word_t param_data;
    logic         param_ack;
    logic         tile_valid;
    tile_t        tile_data;
    logic         tile_ready;
    logic         out_valid;
    out_block_t   out_block;

    // expected blocks in acceptance order
    out_block_t exp_mem [exp_depth];
    int         in_count    = 0;
    int         out_count   = 0;
    int         cycles      = 0;
    int         req_weights = 0;
    int         req_bias    = 0;

    // parameters as the model sees them
    weights_t                  model_w;
    logic signed [param_w-1:0] model_b;
    logic [31:0]               rng_state = 32'd15160;

    `include "tb_conv_model.svh"

    conv_engine_top i_conv_engine_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .param_req    (param_req),
        .param_is_bias(param_is_bias),
        .param_data   (param_data),
        .param_ack    (param_ack),
        .tile_valid   (tile_valid),
        .tile_data    (tile_data),
        .tile_ready   (tile_ready),
        .out_valid    (out_valid),
        .out_block    (out_block)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic draw(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    task automatic draw_weights(output weights_t w);
        logic [31:0] lo;
        logic [31:0] hi;
        int          c;
        for (c = 0; c < ch_num; c++) begin
            draw(lo);
            draw(hi);
            w[c*36 +: 36] = {hi[3:0], lo};
        end
    endtask

    task automatic draw_tile(output tile_t t);
        logic [31:0] v;
        int          i;
        for (i = 0; i < 16; i++) begin
            draw(v);
            t[i*32 +: 32] = v;
        end
    endtask

    // host side of the four-phase handshake
    // called right after a rising edge
    task automatic send_param(input logic is_bias, input weight_word_t data);
        param_req     <= 1'b1;
        param_is_bias <= is_bias;
        param_data    <= data;
        if (is_bias) begin
            req_bias <= req_bias + 1;
        end else begin
            req_weights <= req_weights + 1;
        end
        do @(posedge clk); while (!param_ack);
        param_req <= 1'b0;
        do @(posedge clk); while (param_ack);
    endtask

    // channel 0 goes first so it ends up in the lowest slot
    task automatic load_set(input weights_t w, input logic signed [param_w-1:0] b,
                            input logic with_bias);
        int c;
        for (c = 0; c < ch_num; c++) begin
            send_param(1'b0, w[c*36 +: 36]);
        end
        if (with_bias) begin
            send_param(1'b1, weight_word_t'(b));
            model_b = b;
        end
        model_w = w;
    endtask

    task automatic send_tile(input tile_t t, input out_block_t exp);
        tile_valid        <= 1'b1;
        tile_data         <= t;
        exp_mem[in_count] <= exp;
        in_count          <= in_count + 1;
        @(posedge clk);
    endtask

    task automatic wait_drain();
        tile_valid <= 1'b0;
        while (out_count != in_count) @(posedge clk);
    endtask

    task automatic run_random_tiles(input int n);
        tile_t t;
        int    i;
        for (i = 0; i < n; i++) begin
            draw_tile(t);
            send_tile(t, conv_expect(t, model_w, model_b));
        end
        wait_drain();
    endtask

    always @(posedge clk) begin
        if (out_valid) begin
            out_count <= out_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            abort_run();
        end
    end

    reset_values: assert property (
        @(posedge clk) !rst_n |=> (!param_ack && !tile_ready && !out_valid)
    ) else begin
        $display("outputs were not low after reset at %0t", $time);
        abort_run();
    end

    ack_rise: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(param_ack) |-> ($past(param_req) && param_req)
    ) else begin
        $display("param_ack rose without param_req high at %0t", $time);
        abort_run();
    end

    ack_fall: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(param_ack) |-> !$past(param_req)
    ) else begin
        $display("param_ack fell before param_req was dropped at %0t", $time);
        abort_run();
    end

    ready_early: assert property (
        @(posedge clk) disable iff (!rst_n)
        tile_ready |-> (req_weights >= ch_num && req_bias >= 1)
    ) else begin
        $display("tile_ready rose before a full parameter set at %0t", $time);
        abort_run();
    end

    ready_after_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_weights >= ch_num && req_bias >= 1 && !param_req && !param_ack) |-> tile_ready
    ) else begin
        $display("tile_ready still low after a full parameter set at %0t", $time);
        abort_run();
    end

    ready_kept: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(tile_ready) |-> tile_ready
    ) else begin
        $display("tile_ready dropped after going high at %0t", $time);
        abort_run();
    end

    // accept edge plus four
    out_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(tile_valid && tile_ready, 4)
    ) else begin
        $display("MISMATCH time=%0t out_valid got=%0b exp=%0b", $time,
                 $sampled(out_valid), !$sampled(out_valid));
        abort_run();
    end

    block_value: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_block == exp_mem[out_count])
    ) else begin
        $display("MISMATCH time=%0t out_block got=%h exp=%h", $time,
                 $sampled(out_block), $sampled(exp_mem[out_count]));
        abort_run();
    end

    initial begin
        weights_t    w;
        logic [31:0] v;
        rst_n         = 1'b0;
        param_req     = 1'b0;
        param_is_bias = 1'b0;
        param_data    = '0;
        tile_valid    = 1'b0;
        tile_data     = '0;
        model_w       = '0;
        model_b       = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // a tile offered before any parameters must not be taken
        tile_valid <= 1'b1;
        tile_data  <= {64{8'h5a}};
        repeat (2) @(posedge clk);
        tile_valid <= 1'b0;

        // first random parameter set and back-to-back tiles
        draw_weights(w);
        draw(v);
        load_set(w, v[3:0], 1'b1);
        run_random_tiles(rand_tiles);

        // saturation at both ends
        load_set({ch_num{36'h777777777}}, 4'sd3, 1'b1);
        send_tile({64{8'h7f}}, {out_pos{8'h7f}});
        wait_drain();
        load_set({ch_num{36'h888888888}}, 4'sd3, 1'b0);
        send_tile({64{8'h7f}}, '0);
        wait_drain();

        // reload with fresh parameters
        draw_weights(w);
        draw(v);
        load_set(w, v[3:0], 1'b1);
        run_random_tiles(reload_tiles);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
cnn_pkg.sv
param_loader.sv
window_gather.sv
mac_array.sv
requantize.sv
conv_engine_top.sv
tb_conv_engine.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_conv_engine -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_conv_engine)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
